//--- Bender.yml
package:
  name: axist_to_avst_tx

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axist_avst_pkg.sv
      - rtl/tx_beat_convert.sv
      - rtl/tx_ready_fifo.sv
      - rtl/axist_to_avst_tx.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_axist_to_avst_tx.sv

//--- axist_to_avst_tx.f
+incdir+rtl
rtl/axist_avst_pkg.sv
rtl/tx_beat_convert.sv
rtl/tx_ready_fifo.sv
rtl/axist_to_avst_tx.sv
test/tb_axist_to_avst_tx.sv

//--- rtl/axist_avst_config.svh
// build-time sizes for the AXI-Stream to Avalon-ST tx bridge
// TX_FIFO_DEPTH must exceed TX_FIFO_SLACK plus two beats in flight

`ifndef AXIST_AVST_CONFIG_SVH
`define AXIST_AVST_CONFIG_SVH

// bytes carried by one beat on both sides
`define TX_DATA_BYTES 8

// sideband error bits per beat, bit 0 marks a data error
`define TX_USER_BITS 2

// buffer entries between converter and MAC
`define TX_FIFO_DEPTH 16

// entries kept free for beats already past the tready decision
`define TX_FIFO_SLACK 2

`endif

//--- rtl/axist_avst_pkg.sv
// beat types for the tx bridge, sized from axist_avst_config.svh
// empty is log2 of the byte count wide, so a beat never carries zero bytes

`include "axist_avst_config.svh"

package axist_avst_pkg;

	typedef logic [`TX_DATA_BYTES*8-1:0]         tx_data_t;
	typedef logic [`TX_DATA_BYTES-1:0]           tx_keep_t;
	typedef logic [$clog2(`TX_DATA_BYTES)-1:0]   tx_empty_t;
	typedef logic [`TX_USER_BITS-1:0]            tx_user_t;

	// user side beat, byte 0 in the low lane
	typedef struct packed {
		tx_data_t data;
		tx_keep_t keep;
		logic     last;
		tx_user_t user;
		// expected to equal the inverted xor of data
		logic     parity;
	} axis_beat_t;

	// MAC side beat, byte 0 in the high lane
	typedef struct packed {
		tx_data_t  data;
		tx_empty_t empty;
		logic      sop;
		logic      eop;
		tx_user_t  user;
	} avst_beat_t;

endpackage

//--- rtl/axist_to_avst_tx.sv
// AXI-Stream to Avalon-ST tx bridge, SOP-aligned, one clock
// valid follows MAC ready in the same cycle, a beat pops whenever valid is high

`timescale 1ns/1ps

`include "axist_avst_config.svh"

module axist_to_avst_tx
	import axist_avst_pkg::*;
(
	input  logic       i_tx_clk,
	input  logic       i_tx_reset_n,
	input  logic       i_axist_tx_tvalid,
	input  axis_beat_t i_axist_tx_beat,
	output logic       o_axist_tx_tready,
	input  logic       i_avst_tx_ready,
	output logic       o_avst_tx_valid,
	output avst_beat_t o_avst_tx_beat,
	output logic       o_axist_tx_parity_error
);

	logic                                  wr_en;
	avst_beat_t                            wr_beat;
	logic                                  fifo_empty;
	logic [$clog2(`TX_FIFO_DEPTH + 1)-1:0] fifo_level;

	tx_beat_convert tx_beat_convert_i (
		.i_tx_clk                (i_tx_clk),
		.i_tx_reset_n            (i_tx_reset_n),
		.i_axist_tx_tvalid       (i_axist_tx_tvalid),
		.i_axist_tx_beat         (i_axist_tx_beat),
		.i_fifo_level            (fifo_level),
		.o_axist_tx_tready       (o_axist_tx_tready),
		.o_wr_en                 (wr_en),
		.o_wr_beat               (wr_beat),
		.o_axist_tx_parity_error (o_axist_tx_parity_error)
	);

	// MAC ready pops the head directly
	assign o_avst_tx_valid = !fifo_empty && i_avst_tx_ready;

	tx_ready_fifo #(
		.T (avst_beat_t)
	) tx_ready_fifo_i (
		.i_tx_clk     (i_tx_clk),
		.i_tx_reset_n (i_tx_reset_n),
		.i_wr_en      (wr_en),
		.i_wr_data    (wr_beat),
		.i_rd_en      (o_avst_tx_valid),
		.o_rd_data    (o_avst_tx_beat),
		.o_empty      (fifo_empty),
		.o_level      (fifo_level)
	);

endmodule

//--- rtl/tx_beat_convert.sv
// one register stage from AXI-Stream beat to Avalon-ST beat, single packet per beat
// the FIFO behind it must take every o_wr_en, room is kept through tready

`timescale 1ns/1ps

`include "axist_avst_config.svh"

module tx_beat_convert
	import axist_avst_pkg::*;
(
	input  logic                                   i_tx_clk,
	input  logic                                   i_tx_reset_n,
	input  logic                                   i_axist_tx_tvalid,
	input  axis_beat_t                             i_axist_tx_beat,
	input  logic [$clog2(`TX_FIFO_DEPTH + 1)-1:0]  i_fifo_level,
	output logic                                   o_axist_tx_tready,
	output logic                                   o_wr_en,
	output avst_beat_t                             o_wr_beat,
	output logic                                   o_axist_tx_parity_error
);

	localparam int LVL_W = $clog2(`TX_FIFO_DEPTH + 1);
	localparam logic [LVL_W:0] TREADY_LIMIT = (LVL_W + 1)'(`TX_FIFO_DEPTH - `TX_FIFO_SLACK);

	//**********************************************************************
	// helpers
	//**********************************************************************

	// avalon wants byte 0 in the most significant lane
	function automatic tx_data_t reverse_bytes(input tx_data_t din);
		tx_data_t dout;
		for (int b = 0; b < `TX_DATA_BYTES; b++) begin
			dout[b*8 +: 8] = din[(`TX_DATA_BYTES - 1 - b)*8 +: 8];
		end
		return dout;
	endfunction

	// unused bytes on the last beat
	function automatic tx_empty_t keep_to_empty(input tx_keep_t keep);
		tx_empty_t cnt;
		cnt = '0;
		for (int b = 0; b < `TX_DATA_BYTES; b++) begin
			if (!keep[b]) begin
				cnt = cnt + 1'b1;
			end
		end
		return cnt;
	endfunction

	//**********************************************************************
	// accept and convert
	//**********************************************************************

	logic           accept;
	logic           parity_bad;
	logic           sop_pending;
	logic [LVL_W:0] load;
	avst_beat_t     next_beat;

	assign accept     = i_axist_tx_tvalid && o_axist_tx_tready;
	assign parity_bad = i_axist_tx_beat.parity != ~(^i_axist_tx_beat.data);

	always_comb begin
		next_beat.data  = reverse_bytes(i_axist_tx_beat.data);
		next_beat.empty = i_axist_tx_beat.last ? keep_to_empty(i_axist_tx_beat.keep) : '0;
		next_beat.sop   = sop_pending;
		next_beat.eop   = i_axist_tx_beat.last;
		next_beat.user  = i_axist_tx_beat.user;
		// bad parity marks the beat as a data error
		if (parity_bad) begin
			next_beat.user[0] = 1'b1;
		end
	end

	// worst case fill after this edge: no pop, pending write lands,
	// plus the beat taken now
	assign load = {1'b0, i_fifo_level}
		+ {{LVL_W{1'b0}}, o_wr_en}
		+ {{LVL_W{1'b0}}, accept};

	always_ff @(posedge i_tx_clk or negedge i_tx_reset_n) begin
		if (!i_tx_reset_n) begin
			o_axist_tx_tready       <= 1'b0;
			o_wr_en                 <= 1'b0;
			o_axist_tx_parity_error <= 1'b0;
			sop_pending             <= 1'b1;
		end else begin
			o_axist_tx_tready       <= load < TREADY_LIMIT;
			o_wr_en                 <= accept;
			o_axist_tx_parity_error <= accept && parity_bad;
			// next beat opens a packet only after a last beat
			if (accept) begin
				sop_pending <= i_axist_tx_beat.last;
			end
		end
	end

	always_ff @(posedge i_tx_clk) begin
		if (accept) begin
			o_wr_beat <= next_beat;
		end
	end

	//**********************************************************************
	// user side keep rules
	//**********************************************************************

	a_keep_nonzero: assert property (
		@(posedge i_tx_clk) disable iff (!i_tx_reset_n)
		accept |-> |i_axist_tx_beat.keep
	) else $error("accepted beat with no valid bytes");

	// packets only end short on the last beat
	a_keep_full_mid: assert property (
		@(posedge i_tx_clk) disable iff (!i_tx_reset_n)
		accept && !i_axist_tx_beat.last |-> &i_axist_tx_beat.keep
	) else $error("partial keep on a non-last beat");

endmodule

//--- rtl/tx_ready_fifo.sv
// single clock show-ahead FIFO, the head is valid whenever o_empty is low
// no guard on overflow or underflow, the writer and reader own that

`timescale 1ns/1ps

`include "axist_avst_config.svh"

module tx_ready_fifo #(
	parameter type T = logic
) (
	input  logic                                   i_tx_clk,
	input  logic                                   i_tx_reset_n,
	input  logic                                   i_wr_en,
	input  T                                       i_wr_data,
	input  logic                                   i_rd_en,
	output T                                       o_rd_data,
	output logic                                   o_empty,
	output logic [$clog2(`TX_FIFO_DEPTH + 1)-1:0]  o_level
);

	localparam int DEPTH = `TX_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int LVL_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LVL_W-1:0] level;
	logic             full;

	// wrap works for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	//**********************************************************************
	// storage
	//**********************************************************************

	always_ff @(posedge i_tx_clk) begin
		if (i_wr_en) begin
			mem[wr_ptr] <= i_wr_data;
		end
	end

	assign o_rd_data = mem[rd_ptr];

	//**********************************************************************
	// pointers and fill level
	//**********************************************************************

	always_ff @(posedge i_tx_clk or negedge i_tx_reset_n) begin
		if (!i_tx_reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (i_wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (i_rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({i_wr_en, i_rd_en})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	assign full    = level == LVL_W'(DEPTH);
	assign o_empty = level == '0;
	assign o_level = level;

	a_no_overflow: assert property (
		@(posedge i_tx_clk) disable iff (!i_tx_reset_n)
		i_wr_en |-> !full
	) else $error("write into a full FIFO");

	a_no_underflow: assert property (
		@(posedge i_tx_clk) disable iff (!i_tx_reset_n)
		i_rd_en |-> !o_empty
	) else $error("read from an empty FIFO");

endmodule

//--- test/tb_axist_to_avst_tx.sv
// directed tests for the AXI-Stream to Avalon-ST tx bridge
// MAC ready stays high except in the back-pressure test

`timescale 1ns/1ps

`include "axist_avst_config.svh"

module tb_axist_to_avst_tx
	import axist_avst_pkg::*;
();

	// five short tests of well under 200 cycles plus a wide margin
	localparam int CYCLE_LIMIT = 2000;

	logic       tx_clk = 1'b0;
	logic       tx_reset_n;
	logic       axist_tvalid;
	axis_beat_t axist_beat;
	logic       avst_ready;
	logic       axist_tready;
	logic       avst_valid;
	avst_beat_t avst_beat;
	logic       parity_error;

	avst_beat_t exp_q[$];
	logic       sop_flag;
	int         cycle_count = 0;

	axist_to_avst_tx axist_to_avst_tx_i (
		.i_tx_clk                (tx_clk),
		.i_tx_reset_n            (tx_reset_n),
		.i_axist_tx_tvalid       (axist_tvalid),
		.i_axist_tx_beat         (axist_beat),
		.o_axist_tx_tready       (axist_tready),
		.i_avst_tx_ready         (avst_ready),
		.o_avst_tx_valid         (avst_valid),
		.o_avst_tx_beat          (avst_beat),
		.o_axist_tx_parity_error (parity_error)
	);

	always #20 tx_clk = ~tx_clk;

	//**********************************************************************
	// failure reporting and compares
	//**********************************************************************

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic compare_beat(input avst_beat_t got, input avst_beat_t exp);
		if (got !== exp) begin
			$display("Error: o_avst_tx_beat got %h expected %h", got, exp);
			fail_run("Avalon beat does not match the model");
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			fail_run("single bit output has the wrong value");
		end
	endtask

	always @(posedge tx_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			fail_run("run did not finish within the cycle limit");
		end
	end

	//**********************************************************************
	// reference model
	//**********************************************************************

	// byte i of the AXI beat lands in lane 7 - i on Avalon
	function automatic avst_beat_t model_beat(input axis_beat_t in, input logic sop);
		avst_beat_t m;
		for (int i = 0; i < `TX_DATA_BYTES; i++) begin
			m.data[(`TX_DATA_BYTES - 1 - i)*8 +: 8] = in.data[i*8 +: 8];
		end
		m.empty = in.last ? tx_empty_t'(`TX_DATA_BYTES - $countones(in.keep)) : '0;
		m.sop   = sop;
		m.eop   = in.last;
		m.user  = in.user;
		if (in.parity !== ~(^in.data)) begin
			m.user[0] = 1'b1;
		end
		return m;
	endfunction

	function automatic axis_beat_t make_beat(input logic last, input tx_keep_t keep,
		input logic corrupt);
		axis_beat_t b;
		b.data   = {$urandom(), $urandom()};
		b.keep   = keep;
		b.last   = last;
		// user bit 1 passes through untouched
		b.user   = tx_user_t'($urandom() & 2);
		b.parity = ~(^b.data) ^ corrupt;
		return b;
	endfunction

	// each popped beat is checked just before the edge that pops it
	always begin
		@(negedge tx_clk);
		#15;
		if (avst_valid === 1'b1) begin
			if (avst_ready !== 1'b1) begin
				fail_run("Avalon valid is high while MAC ready is low");
			end else if (exp_q.size() == 0) begin
				fail_run("a beat came out with none expected");
			end else begin
				compare_beat(avst_beat, exp_q.pop_front());
			end
		end
	end

	//**********************************************************************
	// drivers called on a falling edge
	//**********************************************************************

	task automatic offer_beat(input axis_beat_t beat, input int max_wait, output bit taken);
		int   waited;
		logic bad;
		waited       = 0;
		taken        = 1'b0;
		bad          = beat.parity !== ~(^beat.data);
		axist_tvalid = 1'b1;
		axist_beat   = beat;
		while (axist_tready !== 1'b1 && waited < max_wait) begin
			@(negedge tx_clk);
			waited++;
		end
		// tready high here means the next rising edge takes the beat
		if (axist_tready === 1'b1) begin
			exp_q.push_back(model_beat(beat, sop_flag));
			sop_flag = beat.last;
			@(negedge tx_clk);
			compare_bit("o_axist_tx_parity_error", parity_error, bad);
			axist_tvalid = 1'b0;
			taken        = 1'b1;
		end
	endtask

	task automatic send_beat(input logic last, input tx_keep_t keep, input logic corrupt);
		bit taken;
		offer_beat(make_beat(last, keep, corrupt), CYCLE_LIMIT, taken);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge tx_clk);
		end
		@(negedge tx_clk);
	endtask

	//**********************************************************************
	// tests
	//**********************************************************************

	task automatic test_reset_values();
		compare_bit("o_axist_tx_tready", axist_tready, 1'b0);
		compare_bit("o_avst_tx_valid", avst_valid, 1'b0);
		compare_bit("o_axist_tx_parity_error", parity_error, 1'b0);
	endtask

	task automatic test_single_beat();
		send_beat(1'b1, 8'h1F, 1'b0);
		wait_drain();
	endtask

	task automatic test_two_packets();
		send_beat(1'b0, 8'hFF, 1'b0);
		send_beat(1'b0, 8'hFF, 1'b0);
		send_beat(1'b0, 8'hFF, 1'b0);
		send_beat(1'b1, 8'h0F, 1'b0);
		send_beat(1'b0, 8'hFF, 1'b0);
		send_beat(1'b1, 8'h03, 1'b0);
		wait_drain();
	endtask

	task automatic test_parity();
		send_beat(1'b0, 8'hFF, 1'b0);
		send_beat(1'b0, 8'hFF, 1'b1);
		send_beat(1'b0, 8'hFF, 1'b0);
		send_beat(1'b1, 8'h7F, 1'b1);
		send_beat(1'b1, 8'hFF, 1'b0);
		wait_drain();
	endtask

	task automatic test_backpressure();
		axis_beat_t beat;
		bit         taken;
		int         accepted;
		accepted   = 0;
		taken      = 1'b1;
		avst_ready = 1'b0;
		while (taken && accepted < 2*`TX_FIFO_DEPTH) begin
			beat = make_beat(accepted % 5 == 4, '1, 1'b0);
			offer_beat(beat, 4, taken);
			if (taken) begin
				accepted++;
			end
		end
		if (taken) begin
			fail_run("tready never fell while MAC ready was low");
		end else if (accepted > `TX_FIFO_DEPTH - `TX_FIFO_SLACK) begin
			fail_run("more beats taken than the FIFO can hold with its reserve");
		end else begin
			// the stalled beat is still held on the AXI side
			avst_ready = 1'b1;
			offer_beat(beat, CYCLE_LIMIT, taken);
			send_beat(1'b0, 8'hFF, 1'b0);
			send_beat(1'b1, 8'h07, 1'b0);
			wait_drain();
		end
	endtask

	initial begin
		void'($urandom(53));
		tx_reset_n   = 1'b0;
		axist_tvalid = 1'b0;
		axist_beat   = '0;
		avst_ready   = 1'b1;
		sop_flag     = 1'b1;
		repeat (4) @(posedge tx_clk);
		@(negedge tx_clk);
		test_reset_values();
		tx_reset_n = 1'b1;
		@(negedge tx_clk);
		compare_bit("o_axist_tx_tready", axist_tready, 1'b1);
		test_single_beat();
		test_two_packets();
		test_parity();
		test_backpressure();
		if (exp_q.size() == 0 && avst_valid === 1'b0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			fail_run("beats left over at the end of the run");
		end
	end

endmodule
